// ==== files.f ====
+incdir+.
i2c_pkg.sv
i2c_bit_if.sv
i2c_bit_timing.sv
i2c_bit_engine.sv
i2c_transaction_fsm.sv
i2c_master_top.sv
i2c_target_model.sv
tb_i2c_master.sv

// ==== i2c_bit_engine.sv ====
`timescale 1ns/10ps

module i2c_bit_engine import i2c_pkg::*; (
    input  logic            clock,
    input  logic            reset_n,
    i2c_bit_if.engine       bus,
    input  logic            tick,
    input  logic            stretch_expired,
    input  logic            scl_in,
    input  logic            sda_in,
    output logic            stretch_wait,
    output logic            scl_low,
    output logic            sda_low
);

    logic       active;
    logic [1:0] phase;
    logic       ack_q;
    logic       rx_q;
    logic       timed_out_q;
    logic       is_start;
    logic       sda_setup_low;
    logic       finish_bit;

    assign bus.ack       = ack_q;
    assign bus.rx_bit    = rx_q;
    assign bus.timed_out = timed_out_q;

    assign is_start     = (bus.cmd == CMD_START) || (bus.cmd == CMD_RESTART);
    assign stretch_wait = active && (phase == 2'd2);
    assign finish_bit   = active && tick && (phase == 2'd3);

    // SDA level set up in the first phase, while SCL is low
    always_comb begin
        case (bus.cmd)
            CMD_STOP:      sda_setup_low = 1'b1;
            CMD_WRITE_BIT: sda_setup_low = !bus.tx_bit;
            CMD_READ_BIT:  sda_setup_low = 1'b0;
            default:       sda_setup_low = 1'b0;
        endcase
    end

    ////////////////////
    // Phase sequencing
    ////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            active      <= 1'b0;
            phase       <= 2'd0;
            scl_low     <= 1'b0;
            sda_low     <= 1'b0;
            ack_q       <= 1'b0;
            timed_out_q <= 1'b0;
        end else begin
            if (ack_q && !bus.req) begin
                ack_q <= 1'b0;
            end

            if (!active) begin
                if (bus.req && !ack_q) begin
                    active      <= 1'b1;
                    phase       <= 2'd0;
                    timed_out_q <= 1'b0;
                end
            end else if (tick) begin
                case (phase)
                    2'd0: begin
                        sda_low <= sda_setup_low;
                        phase   <= 2'd1;
                    end
                    2'd1: begin
                        scl_low <= 1'b0;
                        phase   <= 2'd2;
                    end
                    2'd2: begin
                        // Target may hold SCL low here
                        if (scl_in) begin
                            if (is_start) begin
                                sda_low <= 1'b1;
                            end
                            phase <= 2'd3;
                        end else if (stretch_expired) begin
                            sda_low     <= 1'b0;
                            timed_out_q <= 1'b1;
                            ack_q       <= 1'b1;
                            active      <= 1'b0;
                        end
                    end
                    default: begin
                        // STOP leaves SCL high and lets SDA rise
                        if (bus.cmd == CMD_STOP) begin
                            sda_low <= 1'b0;
                        end else begin
                            scl_low <= 1'b1;
                        end
                        ack_q  <= 1'b1;
                        active <= 1'b0;
                    end
                endcase
            end
        end
    end

    // Sampled just before SCL falls
    always_ff @(posedge clock) begin
        if (finish_bit) begin
            rx_q <= sda_in;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_ack_needs_req: assert property (
        @(posedge clock) disable iff (!reset_n) $rose(bus.ack) |-> bus.req
    );

    a_scl_on_tick: assert property (
        @(posedge clock) disable iff (!reset_n) !$stable(scl_low) |-> $past(tick)
    );

endmodule

// ==== i2c_bit_if.sv ====
`timescale 1ns/10ps

interface i2c_bit_if import i2c_pkg::*; ();

    logic       req;
    bit_cmd_t   cmd;
    logic       tx_bit;
    logic       ack;
    logic       rx_bit;
    logic       timed_out;

    modport sequencer (
        output req,
        output cmd,
        output tx_bit,
        input  ack,
        input  rx_bit,
        input  timed_out
    );

    modport engine (
        input  req,
        input  cmd,
        input  tx_bit,
        output ack,
        output rx_bit,
        output timed_out
    );

endinterface

// ==== i2c_bit_timing.sv ====
`timescale 1ns/10ps
`include "i2c_params.svh"

module i2c_bit_timing import i2c_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  divider_t    divider,
    input  logic        stretch_wait,
    output logic        tick,
    output logic        stretch_expired
);

    divider_t       div_count;
    stretch_count_t stretch_count;

    ////////////////////
    // Bus rate tick
    ////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            div_count <= '0;
            tick      <= 1'b0;
        end else if (div_count >= divider) begin
            div_count <= '0;
            tick      <= 1'b1;
        end else begin
            div_count <= div_count + 1'b1;
            tick      <= 1'b0;
        end
    end

    ////////////////////
    // Stretch timeout
    ////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n || !stretch_wait) begin
            stretch_count <= '0;
        end else if (tick && stretch_count < stretch_count_t'(`I2C_STRETCH_MAX_TICKS)) begin
            stretch_count <= stretch_count + 1'b1;
        end
    end

    assign stretch_expired = stretch_wait &&
                             (stretch_count == stretch_count_t'(`I2C_STRETCH_MAX_TICKS));

    // A count left over from an earlier wait never expires a new one
    a_expired_only_waiting: assert property (
        @(posedge clock) disable iff (!reset_n)
            stretch_expired |-> stretch_wait && $past(stretch_wait)
    );

endmodule

// ==== i2c_master_top.sv ====
`timescale 1ns/10ps

module i2c_master_top import i2c_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        enable,
    input  logic        read_write,
    input  dev_addr_t   device_address,
    input  reg_addr_t   register_address,
    input  data_byte_t  mosi_data,
    input  divider_t    divider,
    output data_byte_t  miso_data,
    output logic        busy,
    output logic        error,
    inout  wire         scl,
    inout  wire         sda
);

    logic tick;
    logic stretch_wait;
    logic stretch_expired;
    logic scl_low;
    logic sda_low;
    logic scl_in;
    logic sda_in;

    i2c_bit_if bit_bus ();

    // Open-drain pads only pull low or release
    assign scl    = scl_low ? 1'b0 : 1'bz;
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign scl_in = scl;
    assign sda_in = sda;

    i2c_bit_timing timing (
        .clock           (clock),
        .reset_n         (reset_n),
        .divider         (divider),
        .stretch_wait    (stretch_wait),
        .tick            (tick),
        .stretch_expired (stretch_expired)
    );

    i2c_bit_engine engine (
        .clock           (clock),
        .reset_n         (reset_n),
        .bus             (bit_bus.engine),
        .tick            (tick),
        .stretch_expired (stretch_expired),
        .scl_in          (scl_in),
        .sda_in          (sda_in),
        .stretch_wait    (stretch_wait),
        .scl_low         (scl_low),
        .sda_low         (sda_low)
    );

    i2c_transaction_fsm sequencer (
        .clock            (clock),
        .reset_n          (reset_n),
        .bus              (bit_bus.sequencer),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .miso_data        (miso_data),
        .busy             (busy),
        .error            (error)
    );

endmodule

// ==== i2c_params.svh ====
`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// Bus field widths
`define I2C_ADDR_WIDTH      7
`define I2C_REG_WIDTH       8
`define I2C_DATA_WIDTH      8

// Rate divider input
`define I2C_DIVIDER_WIDTH   16

// Clock stretch timeout
`define I2C_STRETCH_WIDTH       16
// Divider ticks a stretch may last before the transfer aborts
`define I2C_STRETCH_MAX_TICKS   255

`endif

// ==== i2c_pkg.sv ====
`include "i2c_params.svh"

package i2c_pkg;

    typedef logic [`I2C_ADDR_WIDTH-1:0]     dev_addr_t;
    typedef logic [`I2C_REG_WIDTH-1:0]      reg_addr_t;
    typedef logic [`I2C_DATA_WIDTH-1:0]     data_byte_t;
    typedef logic [`I2C_DIVIDER_WIDTH-1:0]  divider_t;
    typedef logic [`I2C_STRETCH_WIDTH-1:0]  stretch_count_t;

    // Single bus operations handled by the bit engine
    typedef enum logic [2:0] {
        CMD_START,
        CMD_RESTART,
        CMD_WRITE_BIT,
        CMD_READ_BIT,
        CMD_STOP
    } bit_cmd_t;

    // Byte states carry their ack bit as the ninth bit
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_ADDR_W,
        ST_REG,
        ST_DATA,
        ST_RESTART,
        ST_ADDR_R,
        ST_READ,
        ST_STOP
    } txn_state_t;

endpackage

// ==== i2c_target_model.sv ====
`timescale 1ns/10ps

module i2c_target_model import i2c_pkg::*; (
    input  logic        clock,
    input  logic [15:0] stretch_clocks,
    inout  wire         scl,
    inout  wire         sda
);

    localparam dev_addr_t OWN_ADDR = 7'h2a;

    typedef enum logic [2:0] {
        T_IDLE,
        T_ADDR,
        T_REG,
        T_WDATA,
        T_RDATA,
        T_IGNORE
    } target_state_t;

    target_state_t state;
    data_byte_t    mem [0:255];
    data_byte_t    shift;
    data_byte_t    tx_byte;
    reg_addr_t     reg_ptr;
    logic          read_mode;
    logic          scl_hold;
    logic          sda_hold;
    int            bit_cnt;
    int            stretch_left;
    integer        seed;
    integer        i;

    assign scl = scl_hold ? 1'b0 : 1'bz;
    assign sda = sda_hold ? 1'b0 : 1'bz;

    initial begin
        seed = 32'h5bccea45;
        for (i = 0; i < 256; i++) begin
            mem[i] = $random(seed);
        end
        state        = T_IDLE;
        scl_hold     = 1'b0;
        sda_hold     = 1'b0;
        bit_cnt      = 0;
        stretch_left = 0;
        read_mode    = 1'b0;
        reg_ptr      = '0;
    end

    ////////////////////
    // Bus conditions
    ////////////////////

    // START or RESTART
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            state   = T_ADDR;
            bit_cnt = 0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            state = T_IDLE;
        end
    end

    always @(posedge scl) begin
        if (state != T_IDLE && state != T_IGNORE) begin
            if (bit_cnt < 8) begin
                shift = {shift[6:0], sda};
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    ////////////////////
    // Byte handling
    ////////////////////

    always @(negedge scl) begin
        if (state != T_IDLE && state != T_IGNORE) begin
            if (bit_cnt == 8) begin
                if (state == T_RDATA) begin
                    // Master drives its own ack slot
                    sda_hold = 1'b0;
                end else if (state == T_ADDR && shift[7:1] != OWN_ADDR) begin
                    state = T_IGNORE;
                end else begin
                    case (state)
                        T_ADDR:  read_mode = shift[0];
                        T_REG:   reg_ptr = shift;
                        default: mem[reg_ptr] = shift;
                    endcase
                    sda_hold = 1'b1;
                    if (stretch_clocks != 0) begin
                        scl_hold     = 1'b1;
                        stretch_left = stretch_clocks;
                    end
                end
            end else if (bit_cnt == 9) begin
                sda_hold = 1'b0;
                bit_cnt  = 0;
                if (state == T_ADDR && read_mode) begin
                    state    = T_RDATA;
                    tx_byte  = mem[reg_ptr];
                    sda_hold = !tx_byte[7];
                end else if (state == T_ADDR) begin
                    state = T_REG;
                end else if (state == T_REG) begin
                    state = T_WDATA;
                end else if (state == T_RDATA) begin
                    state = T_IGNORE;
                end
            end else if (state == T_RDATA && bit_cnt > 0) begin
                sda_hold = !tx_byte[7 - bit_cnt];
            end
        end
    end

    // Stretch counted on the falling clock so SCL settles before the master samples
    always @(negedge clock) begin
        if (stretch_left > 0) begin
            stretch_left = stretch_left - 1;
            if (stretch_left == 0) begin
                scl_hold = 1'b0;
            end
        end
    end

endmodule

// ==== i2c_transaction_fsm.sv ====
`timescale 1ns/10ps
`include "i2c_params.svh"

module i2c_transaction_fsm import i2c_pkg::*; (
    input  logic            clock,
    input  logic            reset_n,
    i2c_bit_if.sequencer    bus,
    input  logic            enable,
    input  logic            read_write,
    input  dev_addr_t       device_address,
    input  reg_addr_t       register_address,
    input  data_byte_t      mosi_data,
    output data_byte_t      miso_data,
    output logic            busy,
    output logic            error
);

    txn_state_t state;
    logic [3:0] bit_cnt;
    logic       req_q;
    logic       bit_done;
    logic       last_bit;

    dev_addr_t  dev_addr_q;
    reg_addr_t  reg_addr_q;
    data_byte_t data_q;
    logic       rw_q;
    data_byte_t shift;

    assign bus.req  = req_q;
    assign bit_done = req_q && bus.ack;
    // Ninth bit of a byte is the ack slot
    assign last_bit = (bit_cnt == 4'(`I2C_DATA_WIDTH));

    always_comb begin
        bus.cmd    = CMD_WRITE_BIT;
        bus.tx_bit = shift[`I2C_DATA_WIDTH-1];
        case (state)
            ST_START:   bus.cmd = CMD_START;
            ST_RESTART: bus.cmd = CMD_RESTART;
            ST_STOP:    bus.cmd = CMD_STOP;
            ST_READ: begin
                // NACK after the single data byte
                bus.cmd    = last_bit ? CMD_WRITE_BIT : CMD_READ_BIT;
                bus.tx_bit = 1'b1;
            end
            default: begin
                if (last_bit) begin
                    bus.cmd = CMD_READ_BIT;
                end
            end
        endcase
    end

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            busy    <= 1'b0;
            error   <= 1'b0;
            req_q   <= 1'b0;
        end else if (state == ST_IDLE) begin
            if (enable) begin
                state <= ST_START;
                busy  <= 1'b1;
                error <= 1'b0;
            end
        end else if (bit_done) begin
            req_q <= 1'b0;
            if (bus.timed_out) begin
                state <= ST_IDLE;
                busy  <= 1'b0;
                error <= 1'b1;
            end else begin
                case (state)
                    ST_START: begin
                        state   <= ST_ADDR_W;
                        bit_cnt <= '0;
                    end
                    ST_RESTART: begin
                        state   <= ST_ADDR_R;
                        bit_cnt <= '0;
                    end
                    ST_READ: begin
                        if (last_bit) begin
                            state <= ST_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                    ST_STOP: begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                    end
                    default: begin
                        if (!last_bit) begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end else if (bus.rx_bit) begin
                            // Target did not acknowledge
                            state <= ST_STOP;
                            error <= 1'b1;
                        end else begin
                            bit_cnt <= '0;
                            case (state)
                                ST_ADDR_W: state <= ST_REG;
                                ST_REG:    state <= rw_q ? ST_RESTART : ST_DATA;
                                ST_ADDR_R: state <= ST_READ;
                                default:   state <= ST_STOP;
                            endcase
                        end
                    end
                endcase
            end
        end else if (!req_q && !bus.ack) begin
            req_q <= 1'b1;
        end
    end

    ////////////////////
    // Byte shifting
    ////////////////////

    always_ff @(posedge clock) begin
        if (state == ST_IDLE && enable) begin
            dev_addr_q <= device_address;
            reg_addr_q <= register_address;
            data_q     <= mosi_data;
            rw_q       <= read_write;
        end
        if (bit_done && !bus.timed_out) begin
            case (state)
                ST_START:   shift <= {dev_addr_q, 1'b0};
                ST_RESTART: shift <= {dev_addr_q, 1'b1};
                ST_ADDR_W:  shift <= last_bit ? reg_addr_q : shift << 1;
                ST_REG:     shift <= last_bit ? data_q : shift << 1;
                ST_READ: begin
                    if (last_bit) begin
                        miso_data <= shift;
                    end else begin
                        shift <= {shift[`I2C_DATA_WIDTH-2:0], bus.rx_bit};
                    end
                end
                default: begin
                    if (!last_bit) begin
                        shift <= shift << 1;
                    end
                end
            endcase
        end
    end

    a_req_held_until_ack: assert property (
        @(posedge clock) disable iff (!reset_n) $fell(req_q) |-> $past(bus.ack)
    );

endmodule

// ==== tb_i2c_master.sv ====
`timescale 1ns/10ps

module tb_i2c_master import i2c_pkg::*; ();

    localparam dev_addr_t TARGET_ADDR = 7'h2a;
    localparam dev_addr_t ABSENT_ADDR = 7'h11;
    localparam int        CYCLE_LIMIT = 20000;

    logic        clock;
    logic        reset_n;
    logic        enable;
    logic        read_write;
    dev_addr_t   device_address;
    reg_addr_t   register_address;
    data_byte_t  mosi_data;
    divider_t    divider;
    data_byte_t  miso_data;
    logic        busy;
    logic        error;
    logic [15:0] stretch_clocks;
    wire         scl;
    wire         sda;

    data_byte_t  expected_mem [0:255];
    reg_addr_t   written [0:2];
    reg_addr_t   raddr;
    data_byte_t  wdata;
    integer      seed;
    integer      i;
    int          cycle_count;
    int          start_count;
    int          stop_count;

    pullup (scl);
    pullup (sda);

    i2c_master_top uut (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .divider          (divider),
        .miso_data        (miso_data),
        .busy             (busy),
        .error            (error),
        .scl              (scl),
        .sda              (sda)
    );

    i2c_target_model target (
        .clock          (clock),
        .stretch_clocks (stretch_clocks),
        .scl            (scl),
        .sda            (sda)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure($sformatf("timeout after %0d clock cycles", CYCLE_LIMIT));
        end
    end

    // SDA edges under a high SCL
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            start_count++;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            stop_count++;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first failing check");
    endtask

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        assert (actual === expected)
            else report_failure($sformatf("mismatch %s: got 0x%02h, expected 0x%02h",
                                          name, actual, expected));
    endtask

    task automatic run_transaction(input logic rw, input dev_addr_t dev,
                                   input reg_addr_t reg_a, input data_byte_t data);
        @(negedge clock);
        read_write       = rw;
        device_address   = dev;
        register_address = reg_a;
        mosi_data        = data;
        enable           = 1'b1;
        start_count      = 0;
        stop_count       = 0;
        @(negedge clock);
        enable = 1'b0;
        assert (busy === 1'b1) else report_failure("busy did not rise after enable");
        while (busy !== 1'b0) begin
            @(negedge clock);
        end
    endtask

    // Released lines and only the expected START, RESTART and STOP edges
    task automatic check_stopped_bus(input int starts);
        check_value("scl", scl, 8'h01);
        check_value("sda", sda, 8'h01);
        assert (start_count == starts && stop_count == 1)
            else report_failure($sformatf(
                "SDA moved under high SCL outside START/STOP: %0d falls, %0d rises",
                start_count, stop_count));
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        clock            = 1'b0;
        reset_n          = 1'b0;
        enable           = 1'b0;
        read_write       = 1'b0;
        device_address   = '0;
        register_address = '0;
        mosi_data        = '0;
        divider          = 16'd4;
        stretch_clocks   = '0;
        cycle_count      = 0;
        start_count      = 0;
        stop_count       = 0;
        seed             = 32'h5bccea45;
        for (i = 0; i < 256; i++) begin
            expected_mem[i] = $random(seed);
        end
        repeat (3) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        check_value("busy", busy, 8'h00);
        check_value("error", error, 8'h00);
        check_value("scl", scl, 8'h01);
        check_value("sda", sda, 8'h01);

        for (i = 0; i < 3; i++) begin
            written[i] = $random(seed);
            wdata      = $random(seed);
            run_transaction(1'b0, TARGET_ADDR, written[i], wdata);
            expected_mem[written[i]] = wdata;
            check_value("error", error, 8'h00);
            check_value("target register", target.mem[written[i]], wdata);
            check_stopped_bus(1);
        end

        // Read back, then one untouched register
        for (i = 0; i < 4; i++) begin
            if (i < 3) begin
                raddr = written[i];
            end else begin
                raddr = $random(seed);
            end
            run_transaction(1'b1, TARGET_ADDR, raddr, 8'h00);
            check_value("error", error, 8'h00);
            check_value("miso_data", miso_data, expected_mem[raddr]);
            check_stopped_bus(2);
        end

        raddr = $random(seed);
        run_transaction(1'b0, ABSENT_ADDR, raddr, ~expected_mem[raddr]);
        check_value("error", error, 8'h01);
        check_value("target register", target.mem[raddr], expected_mem[raddr]);
        check_stopped_bus(1);

        // Target holds SCL three ticks past the master's release on each ack
        stretch_clocks = 16'd25;
        raddr = $random(seed);
        wdata = $random(seed);
        run_transaction(1'b0, TARGET_ADDR, raddr, wdata);
        expected_mem[raddr] = wdata;
        check_value("error", error, 8'h00);
        check_value("target register", target.mem[raddr], wdata);
        check_stopped_bus(1);

        // Stretch well past the timeout aborts at the address ack
        stretch_clocks = 16'd2000;
        raddr = $random(seed);
        run_transaction(1'b0, TARGET_ADDR, raddr, ~expected_mem[raddr]);
        check_value("error", error, 8'h01);
        check_value("target register", target.mem[raddr], expected_mem[raddr]);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
